//--- forwardUnit.f
hdl/rvPkg.sv
hdl/bypassIf.sv
hdl/bypassNetwork.sv
hdl/hazardUnit.sv
hdl/operandFetch.sv
hdl/forwardTop.sv
testbench/forwardTb.sv

//--- hdl/bypassIf.sv
//////////////////////////////
// Bypass bus
// Operand reads plus execute and load writes
//////////////////////////////
`timescale 1ns/1ps

interface bypassIf;

    // Execute stage result
    logic            writeEnable;
    rvPkg::regAddr_t writeAddr;
    rvPkg::word_t    writeValue;

    // Returning load data
    logic            loadWriteEnable;
    rvPkg::regAddr_t loadWriteAddr;
    rvPkg::word_t    loadWriteValue;

    // Operand read ports
    rvPkg::regAddr_t readAddr1;
    rvPkg::regAddr_t readAddr2;

    // Bypass lookup results
    logic            hit1;
    logic            hit2;
    rvPkg::word_t    readValue1;
    rvPkg::word_t    readValue2;

    modport network (
        input  writeEnable, writeAddr, writeValue,
        input  loadWriteEnable, loadWriteAddr, loadWriteValue,
        input  readAddr1, readAddr2,
        output hit1, hit2, readValue1, readValue2
    );

    modport fetch (
        input readAddr1, readAddr2,
        input hit1, hit2, readValue1, readValue2
    );

    modport hazard (
        input readAddr1, readAddr2,
        input loadWriteEnable, loadWriteAddr
    );

endinterface

//--- hdl/bypassNetwork.sv
//////////////////////////////
// Bypass network
// Result pipeline with CAM lookup and retire output
//////////////////////////////
`timescale 1ns/1ps

module bypassNetwork (
    input  logic              clk,
    input  logic              arstN,
    bypassIf.network          bus,
    input  logic              stall,
    input  logic              flush,
    output rvPkg::pipeEntry_t retireEntry
);

    typedef logic [$clog2(rvPkg::BypassDepth)-1:0] stageIndex_t;

    // Lowest set bit wins, which is the youngest stage
    function automatic stageIndex_t lowestHit(input logic [rvPkg::BypassDepth-1:0] hits);
        stageIndex_t index;
        index = '0;
        for (int i = rvPkg::BypassDepth - 1; i >= 0; i--) begin
            if (hits[i]) begin
                index = stageIndex_t'(i);
            end
        end
        return index;
    endfunction

    // Stage 0 is youngest, last stage retires
    rvPkg::pipeEntry_t stages [rvPkg::BypassDepth];

    // Per read port lookup state
    rvPkg::regAddr_t               readAddr  [rvPkg::ReadPortCount];
    logic                          hit       [rvPkg::ReadPortCount];
    rvPkg::word_t                  readValue [rvPkg::ReadPortCount];
    logic                          loadHit   [rvPkg::ReadPortCount];
    logic [rvPkg::BypassDepth-1:0] camHits   [rvPkg::ReadPortCount];
    stageIndex_t                   camIndex  [rvPkg::ReadPortCount];

    // Map the two named bus ports onto port arrays
    always_comb begin
        readAddr[0] = bus.readAddr1;
        readAddr[1] = bus.readAddr2;

        bus.hit1       = hit[0];
        bus.hit2       = hit[1];
        bus.readValue1 = readValue[0];
        bus.readValue2 = readValue[1];
    end

    // CAM match and priority select
    always_comb begin
        for (int p = 0; p < rvPkg::ReadPortCount; p++) begin
            loadHit[p] = bus.loadWriteEnable && (bus.loadWriteAddr == readAddr[p]);

            for (int s = 0; s < rvPkg::BypassDepth; s++) begin
                camHits[p][s] = stages[s].valid && (stages[s].addr == readAddr[p]);
            end
            camIndex[p] = lowestHit(camHits[p]);

            if (readAddr[p] == '0) begin
                // x0 is hardwired
                hit[p]       = 1'b1;
                readValue[p] = '0;
            end else if (loadHit[p]) begin
                hit[p]       = 1'b1;
                readValue[p] = bus.loadWriteValue;
            end else if (|camHits[p]) begin
                hit[p]       = 1'b1;
                readValue[p] = stages[camIndex[p]].value;
            end else begin
                // Miss, register file supplies the operand
                hit[p]       = 1'b0;
                readValue[p] = '0;
            end
        end
    end

    // Result pipeline
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < rvPkg::BypassDepth; s++) begin
                stages[s] <= '0;
            end
        end else if (flush) begin
            for (int s = 0; s < rvPkg::BypassDepth; s++) begin
                stages[s] <= '0;
            end
        end else if (!stall) begin
            stages[0] <= '{
                valid: bus.writeEnable,
                addr:  bus.writeAddr,
                value: bus.writeValue
            };

            // Load data lands in stage 1 and the old stage 0 entry is dropped
            if (bus.loadWriteEnable) begin
                stages[1] <= '{
                    valid: 1'b1,
                    addr:  bus.loadWriteAddr,
                    value: bus.loadWriteValue
                };
            end else begin
                stages[1] <= stages[0];
            end

            for (int s = 2; s < rvPkg::BypassDepth; s++) begin
                stages[s] <= stages[s-1];
            end
        end
    end

    assign retireEntry = stages[rvPkg::BypassDepth-1];

    // x0 forwarding never leaks stale pipeline data
    zeroForward: assert property (@(posedge clk) disable iff (!arstN)
        bus.hit1 && (bus.readAddr1 == '0) |-> bus.readValue1 == '0)
        else $error("x0 read forwarded a nonzero value");

    // Producers hold off while the hazard unit stalls
    noWriteInStall: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> !bus.writeEnable && !bus.loadWriteEnable)
        else $error("write accepted during stall");

endmodule

//--- hdl/forwardTop.sv
//////////////////////////////
// Forwarding top level
// Bypass network, hazard unit and operand fetch
//////////////////////////////
`timescale 1ns/1ps

module forwardTop (
    input  logic            clk,
    input  logic            arstN,

    // Execute stage result
    input  logic            writeEnable,
    input  rvPkg::regAddr_t writeAddr,
    input  rvPkg::word_t    writeValue,

    // Load return
    input  logic            loadWriteEnable,
    input  rvPkg::regAddr_t loadWriteAddr,
    input  rvPkg::word_t    loadWriteValue,

    // Load issue
    input  logic            loadIssue,
    input  rvPkg::regAddr_t loadIssueAddr,

    input  logic            flush,

    // Operand reads
    input  rvPkg::regAddr_t readAddr1,
    input  rvPkg::regAddr_t readAddr2,
    output rvPkg::word_t    operand1,
    output rvPkg::word_t    operand2,

    output logic            stall
);

    bypassIf bus ();

    rvPkg::pipeEntry_t retireEntry;

    assign bus.writeEnable     = writeEnable;
    assign bus.writeAddr       = writeAddr;
    assign bus.writeValue      = writeValue;
    assign bus.loadWriteEnable = loadWriteEnable;
    assign bus.loadWriteAddr   = loadWriteAddr;
    assign bus.loadWriteValue  = loadWriteValue;
    assign bus.readAddr1       = readAddr1;
    assign bus.readAddr2       = readAddr2;

    bypassNetwork networkInst (
        .clk         (clk),
        .arstN       (arstN),
        .bus         (bus.network),
        .stall       (stall),
        .flush       (flush),
        .retireEntry (retireEntry)
    );

    hazardUnit hazardInst (
        .clk           (clk),
        .arstN         (arstN),
        .bus           (bus.hazard),
        .loadIssue     (loadIssue),
        .loadIssueAddr (loadIssueAddr),
        .flush         (flush),
        .stall         (stall)
    );

    operandFetch fetchInst (
        .clk         (clk),
        .arstN       (arstN),
        .bus         (bus.fetch),
        .retireEntry (retireEntry),
        .stall       (stall),
        .flush       (flush),
        .operand1    (operand1),
        .operand2    (operand2)
    );

endmodule

//--- hdl/hazardUnit.sv
//////////////////////////////
// Hazard unit
// Tracks one pending load, stalls dependent reads
//////////////////////////////
`timescale 1ns/1ps

module hazardUnit (
    input  logic            clk,
    input  logic            arstN,
    bypassIf.hazard         bus,
    input  logic            loadIssue,
    input  rvPkg::regAddr_t loadIssueAddr,
    input  logic            flush,
    output logic            stall
);

    rvPkg::hazardState_t state;
    rvPkg::hazardState_t stateNext;
    rvPkg::regAddr_t     pendingAddr;

    logic loadReturn;
    logic readMatch1;
    logic readMatch2;

    // The matching load write ends the wait
    assign loadReturn = bus.loadWriteEnable && (bus.loadWriteAddr == pendingAddr);

    assign readMatch1 = (bus.readAddr1 != '0) && (bus.readAddr1 == pendingAddr);
    assign readMatch2 = (bus.readAddr2 != '0) && (bus.readAddr2 == pendingAddr);

    // Drops in the same cycle the load data shows up
    assign stall = (state == rvPkg::waitLoad) && (readMatch1 || readMatch2) && !loadReturn;

    always_comb begin
        stateNext = state;
        case (state)
            rvPkg::idle: begin
                // Loads into x0 never create a hazard
                if (loadIssue && (loadIssueAddr != '0) && !flush) begin
                    stateNext = rvPkg::waitLoad;
                end
            end
            rvPkg::waitLoad: begin
                if (flush || loadReturn) begin
                    stateNext = rvPkg::idle;
                end
            end
            default: stateNext = rvPkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= rvPkg::idle;
        end else begin
            state <= stateNext;
        end
    end

    // Destination of the load in flight
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pendingAddr <= '0;
        end else if (state == rvPkg::idle && loadIssue) begin
            pendingAddr <= loadIssueAddr;
        end
    end

    // Only one load may be outstanding
    singleLoad: assert property (@(posedge clk) disable iff (!arstN)
        state == rvPkg::waitLoad |-> !loadIssue)
        else $error("load issued while another is pending");

endmodule

//--- hdl/operandFetch.sv
//////////////////////////////
// Operand fetch
// Register file plus bypass operand select
//////////////////////////////
`timescale 1ns/1ps

module operandFetch (
    input  logic              clk,
    input  logic              arstN,
    bypassIf.fetch            bus,
    input  rvPkg::pipeEntry_t retireEntry,
    input  logic              stall,
    input  logic              flush,
    output rvPkg::word_t      operand1,
    output rvPkg::word_t      operand2
);

    // Architectural registers x0..x31
    rvPkg::word_t regFile [2**rvPkg::RegAddrWidth];

    logic retireWrite;

    // Retire only when the oldest stage actually leaves the pipeline
    assign retireWrite = retireEntry.valid
                      && !stall
                      && !flush
                      && (retireEntry.addr != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int r = 0; r < 2**rvPkg::RegAddrWidth; r++) begin
                regFile[r] <= '0;
            end
        end else if (retireWrite) begin
            regFile[retireEntry.addr] <= retireEntry.value;
        end
    end

    // Bypass hit overrides the committed value
    always_comb begin
        if (bus.hit1) begin
            operand1 = bus.readValue1;
        end else begin
            operand1 = regFile[bus.readAddr1];
        end
    end

    always_comb begin
        if (bus.hit2) begin
            operand2 = bus.readValue2;
        end else begin
            operand2 = regFile[bus.readAddr2];
        end
    end

endmodule

//--- hdl/rvPkg.sv
//////////////////////////////
// RV32 forwarding package
// Shared widths, bypass pipeline entry and hazard states
//////////////////////////////
package rvPkg;

    // Datapath widths
    localparam int WordWidth    = 32;
    localparam int RegAddrWidth = 5;

    // Bypass pipeline geometry
    localparam int BypassDepth   = 3;
    localparam int ReadPortCount = 2;

    typedef logic [WordWidth-1:0]    word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    // One in-flight result waiting to retire
    typedef struct packed {
        logic     valid;
        regAddr_t addr;
        word_t    value;
    } pipeEntry_t;

    // Outstanding load tracker
    typedef enum logic {
        idle,
        waitLoad
    } hazardState_t;

endpackage

//--- testbench/forwardTb.sv
//////////////////////////////
// Forwarding testbench
// Random stimulus against a reference model
//////////////////////////////
`timescale 1ns/1ps

module forwardTb;

    localparam int StimCycles    = 2000;
    localparam int TimeoutCycles = 2500;
    localparam int RegCount      = 2**rvPkg::RegAddrWidth;

    logic            clk = 1'b0;
    logic            arstN;
    logic            writeEnable;
    rvPkg::regAddr_t writeAddr;
    rvPkg::word_t    writeValue;
    logic            loadWriteEnable;
    rvPkg::regAddr_t loadWriteAddr;
    rvPkg::word_t    loadWriteValue;
    logic            loadIssue;
    rvPkg::regAddr_t loadIssueAddr;
    logic            flush;
    rvPkg::regAddr_t readAddr1;
    rvPkg::regAddr_t readAddr2;
    rvPkg::word_t    operand1;
    rvPkg::word_t    operand2;
    logic            stall;

    integer seed;
    int     cycleCount = 0;

    // Reference model state
    rvPkg::pipeEntry_t modelStages [rvPkg::BypassDepth];
    rvPkg::word_t      modelRegs [RegCount];
    logic              modelPending;
    rvPkg::regAddr_t   modelPendingAddr;

    forwardTop dut_i (
        .clk             (clk),
        .arstN           (arstN),
        .writeEnable     (writeEnable),
        .writeAddr       (writeAddr),
        .writeValue      (writeValue),
        .loadWriteEnable (loadWriteEnable),
        .loadWriteAddr   (loadWriteAddr),
        .loadWriteValue  (loadWriteValue),
        .loadIssue       (loadIssue),
        .loadIssueAddr   (loadIssueAddr),
        .flush           (flush),
        .readAddr1       (readAddr1),
        .readAddr2       (readAddr2),
        .operand1        (operand1),
        .operand2        (operand2),
        .stall           (stall)
    );

    always #2 clk = ~clk;

    // Expected operand for one read address
    function automatic rvPkg::word_t expectedOperand(input rvPkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (loadWriteEnable && (loadWriteAddr == addr)) begin
            return loadWriteValue;
        end
        // Youngest matching stage first
        for (int s = 0; s < rvPkg::BypassDepth; s++) begin
            if (modelStages[s].valid && (modelStages[s].addr == addr)) begin
                return modelStages[s].value;
            end
        end
        return modelRegs[addr];
    endfunction

    function automatic logic expectedStall(input rvPkg::regAddr_t addr1,
                                           input rvPkg::regAddr_t addr2);
        logic match;
        logic loadBack;
        match = ((addr1 != '0) && (addr1 == modelPendingAddr))
             || ((addr2 != '0) && (addr2 == modelPendingAddr));
        loadBack = loadWriteEnable && (loadWriteAddr == modelPendingAddr);
        return modelPending && match && !loadBack;
    endfunction

    task automatic resetModel();
        for (int s = 0; s < rvPkg::BypassDepth; s++) begin
            modelStages[s] = '0;
        end
        for (int r = 0; r < RegCount; r++) begin
            modelRegs[r] = '0;
        end
        modelPending     = 1'b0;
        modelPendingAddr = '0;
    endtask

    // One rising edge of the model
    task automatic updateModel();
        logic stallNow;
        stallNow = expectedStall(readAddr1, readAddr2);
        if (flush) begin
            for (int s = 0; s < rvPkg::BypassDepth; s++) begin
                modelStages[s] = '0;
            end
        end else if (!stallNow) begin
            if (modelStages[2].valid && (modelStages[2].addr != '0)) begin
                modelRegs[modelStages[2].addr] = modelStages[2].value;
            end
            modelStages[2] = modelStages[1];
            if (loadWriteEnable) begin
                modelStages[1] = '{valid: 1'b1, addr: loadWriteAddr, value: loadWriteValue};
            end else begin
                modelStages[1] = modelStages[0];
            end
            modelStages[0] = '{valid: writeEnable, addr: writeAddr, value: writeValue};
        end

        if (flush) begin
            modelPending = 1'b0;
        end else if (modelPending) begin
            if (loadWriteEnable && (loadWriteAddr == modelPendingAddr)) begin
                modelPending = 1'b0;
            end
        end else if (loadIssue && (loadIssueAddr != '0)) begin
            modelPending     = 1'b1;
            modelPendingAddr = loadIssueAddr;
        end
    endtask

    // Small address range so results collide often
    task automatic driveRandomCycle();
        logic [31:0] r;
        r = $random(seed);
        readAddr1       = rvPkg::regAddr_t'(r[2:0]);
        readAddr2       = rvPkg::regAddr_t'(r[5:3]);
        flush           = (r[10:6] == '0);
        loadIssue       = 1'b0;
        loadIssueAddr   = rvPkg::regAddr_t'(r[16:14]);
        loadWriteEnable = 1'b0;
        loadWriteAddr   = modelPendingAddr;
        loadWriteValue  = $random(seed);
        if (!modelPending) begin
            loadIssue = (r[13:11] == '0);
        end else begin
            // Load data returns only for the pending destination
            loadWriteEnable = (r[18:17] == '0);
        end
        writeEnable = r[19];
        writeAddr   = rvPkg::regAddr_t'(r[22:20]);
        writeValue  = $random(seed);
        if (expectedStall(readAddr1, readAddr2)) begin
            writeEnable = 1'b0;
        end
    endtask

    task automatic checkWord(input string name, input rvPkg::word_t actual,
                             input rvPkg::word_t expected);
        if (actual !== expected) begin
            $display("ERR %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %s: actual 0x%h expected 0x%h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic compareOutputs();
        checkWord("operand1", operand1, expectedOperand(readAddr1));
        checkWord("operand2", operand2, expectedOperand(readAddr2));
        checkBit("stall", stall, expectedStall(readAddr1, readAddr2));
    endtask

    always @(posedge clk) begin
        if (arstN) begin
            updateModel();
        end
    end

    // Sample midway between the falling and rising edge
    always begin
        @(negedge clk);
        #1;
        if (arstN) begin
            compareOutputs();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Run did not finish within %0d cycles", TimeoutCycles);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        seed            = 32'h5159b857;
        arstN           = 1'b0;
        writeEnable     = 1'b0;
        writeAddr       = '0;
        writeValue      = '0;
        loadWriteEnable = 1'b0;
        loadWriteAddr   = '0;
        loadWriteValue  = '0;
        loadIssue       = 1'b0;
        loadIssueAddr   = '0;
        flush           = 1'b0;
        readAddr1       = '0;
        readAddr2       = '0;
        resetModel();

        repeat (2) @(negedge clk);
        arstN = 1'b1;

        for (int i = 0; i < StimCycles; i++) begin
            driveRandomCycle();
            @(negedge clk);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
